// File: sim.f
logic/vid_pkg.sv
logic/vid_reg_port.sv
logic/pixel_feeder.sv
logic/palette_lane.sv
logic/rgb_packer.sv
logic/vid_rgb_top.sv
verif/vid_rgb_tb.sv

// File: verif/vid_rgb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vid_rgb_tb
    import vid_pkg::*;
();

    // step opcodes
    localparam int op_wr     = 0;  // a = address, b = data
    localparam int op_rd     = 1;  // a = address, b = expected data
    localparam int op_rd_all = 2;  // every palette entry and control reg vs reference
    localparam int op_pal    = 3;  // write all 48 palette entries, b = pattern
    localparam int op_burst  = 4;  // a = pixel count, b = start index
    localparam int op_sink   = 5;  // a = 0 ready, 1 stalled, 2 random
    localparam int op_fill   = 6;  // offer pixels until the path is full
    localparam int op_drain  = 7;  // wait until every expected pixel is out

    logic                clk_col16x_ntsc;
    logic                rst_n;
    logic                ce;
    logic                rw;
    logic [5:0]          adi;
    logic [7:0]          dbi;
    wire  [7:0]          dbo;
    wire                 dbo_oe;
    logic                pix_in_valid;
    logic [index_w-1:0]  pix_in_index;
    wire                 pix_in_ready;
    logic                out_ready;
    wire                 out_valid;
    wire  [color_w-1:0]  red;
    wire  [color_w-1:0]  green;
    wire  [color_w-1:0]  blue;

    int          step_op [64];
    int          step_a  [64];
    int          step_b  [64];
    int          num_steps = 0;
    logic [5:0]  ref_pal [num_lanes][16];  // what software wrote, per channel
    logic [5:0]  ref_bright;
    logic        ref_blank;
    logic [17:0] exp_q [$];                // expected {red, green, blue} in order
    integer      seed = 32'hcd233e8a;
    logic [31:0] rnd_word;
    int          sink_mode;

    vid_rgb_top dut_i (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .ce              (ce),
        .rw              (rw),
        .adi             (adi),
        .dbi             (dbi),
        .dbo             (dbo),
        .dbo_oe          (dbo_oe),
        .pix_in_valid    (pix_in_valid),
        .pix_in_index    (pix_in_index),
        .pix_in_ready    (pix_in_ready),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .red             (red),
        .green           (green),
        .blue            (blue)
    );

    initial
    begin
        clk_col16x_ntsc = 1'b0;
        forever
            #4 clk_col16x_ntsc = ~clk_col16x_ntsc;  // 8 ns period
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_step(input int op, input int a, input int b);
        step_op[num_steps] = op;
        step_a[num_steps]  = a;
        step_b[num_steps]  = b;
        num_steps++;
    endtask

    // reference model of the output rule
    function automatic logic [17:0] exp_pixel(input logic [3:0] idx);
        int          sum;
        logic [17:0] px;
        px = '0;
        for (int k = 0; k < num_lanes; k++)
        begin
            sum = ref_pal[k][idx] + ref_bright;
            if (ref_blank)
                sum = 0;  // blanked
            else if (sum > 63)
                sum = 63;  // clamp
            px[17-6*k -: 6] = sum[5:0];  // red in the top bits
        end
        return px;
    endfunction

    // what a cpu read of addr should return
    function automatic logic [7:0] ref_read(input logic [5:0] addr);
        reg_addr_u ua;
        ua = addr;
        if (ua.pal.kind != chan_ctrl)
            return {2'b00, ref_pal[int'(ua.pal.kind)][ua.pal.pal_idx]};
        else if (ua.ctrl.reg_num == ctrl_bright)
            return {2'b00, ref_bright};
        else if (ua.ctrl.reg_num == ctrl_blank)
            return {7'd0, ref_blank};
        return 8'h00;  // undefined control reg
    endfunction

    task automatic reg_write(input logic [5:0] addr, input logic [7:0] data);
        reg_addr_u ua;
        ua = addr;
        @(posedge clk_col16x_ntsc);
        ce  <= 1'b0;
        rw  <= 1'b0;
        adi <= addr;
        dbi <= data;
        @(posedge clk_col16x_ntsc);  // write edge
        ce <= 1'b1;
        rw <= 1'b1;
        if (ua.pal.kind != chan_ctrl)
            ref_pal[int'(ua.pal.kind)][ua.pal.pal_idx] = data[5:0];  // 6 bits kept
        else if (ua.ctrl.reg_num == ctrl_bright)
            ref_bright = data[5:0];
        else if (ua.ctrl.reg_num == ctrl_blank)
            ref_blank = data[0];
    endtask

    task automatic reg_read(input logic [5:0] addr, input logic [7:0] expected);
        @(posedge clk_col16x_ntsc);
        ce  <= 1'b0;
        rw  <= 1'b1;
        adi <= addr;
        @(posedge clk_col16x_ntsc);  // read edge
        ce <= 1'b1;
        @(posedge clk_col16x_ntsc);  // data registered one cycle later
        check_value("dbo_oe", dbo_oe, 1);
        check_value($sformatf("dbo[0x%0h]", addr), dbo, expected);
    endtask

    task automatic read_all_regs();
        logic [5:0] addr;
        for (int k = 0; k < num_lanes; k++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                addr = {2'(k), 4'(i)};
                reg_read(addr, ref_read(addr));
            end
        end
        reg_read({chan_ctrl, ctrl_bright}, ref_read({chan_ctrl, ctrl_bright}));
        reg_read({chan_ctrl, ctrl_blank}, ref_read({chan_ctrl, ctrl_blank}));
    endtask

    task automatic fill_palettes(input int pattern);
        for (int k = 0; k < num_lanes; k++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                reg_write({2'(k), 4'(i)}, 8'(i * 5 + k * 17 + pattern));  // top bits set too
            end
        end
    endtask

    task automatic send_burst(input int count, input int start);
        logic [3:0] idx;
        logic       accepted;
        @(posedge clk_col16x_ntsc);
        for (int n = 0; n < count; n++)
        begin
            idx = 4'(start + n * 7 + n / 16);
            pix_in_valid <= 1'b1;
            pix_in_index <= idx;
            accepted = 1'b0;
            while (!accepted)
            begin
                @(posedge clk_col16x_ntsc);
                accepted = pix_in_ready;  // valid already high, so ready means taken
            end
            exp_q.push_back(exp_pixel(idx));
        end
        pix_in_valid <= 1'b0;
    endtask

    // offer pixels with the sink stalled and count what gets in
    task automatic fill_until_full();
        logic [3:0] idx;
        int         taken;
        int         idle;
        idx   = 4'd2;
        taken = 0;
        idle  = 0;
        @(posedge clk_col16x_ntsc);
        pix_in_valid <= 1'b1;
        pix_in_index <= idx;
        while (idle < 8)
        begin
            @(posedge clk_col16x_ntsc);
            if (pix_in_ready)
            begin
                exp_q.push_back(exp_pixel(idx));
                taken++;
                idle = 0;
                idx  = idx + 4'd3;
                pix_in_index <= idx;
            end
            else
                idle++;
        end
        pix_in_valid <= 1'b0;
        check_value("accepted_before_full", taken, 5);  // 1 held + 4 queued
        check_value("out_valid", out_valid, 1);
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0)
            @(posedge clk_col16x_ntsc);
        repeat (4) @(posedge clk_col16x_ntsc);
        check_value("out_valid", out_valid, 0);
        check_value("pix_in_ready", pix_in_ready, 1);  // all credits back
    endtask

    task automatic set_sink(input int mode);
        @(posedge clk_col16x_ntsc);
        sink_mode <= mode;
        repeat (2) @(posedge clk_col16x_ntsc);
    endtask

    // sink side ready pattern
    always @(posedge clk_col16x_ntsc)
    begin
        rnd_word = $random(seed);
        case (sink_mode)
            0:       out_ready <= 1'b1;
            1:       out_ready <= 1'b0;
            default: out_ready <= rnd_word[0];
        endcase
    end

    // scoreboard, compares on every accepted output pixel
    always @(posedge clk_col16x_ntsc)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Error at %0t: output pixel arrived with nothing expected", $time);
                $display("Simulation FAILED");
                $fatal(1);
            end
            else
            begin
                check_value("red", red, exp_q[0][17:12]);
                check_value("green", green, exp_q[0][11:6]);
                check_value("blue", blue, exp_q[0][5:0]);
                void'(exp_q.pop_front());
            end
        end
    end

    // watchdog scaled to the step table
    initial
    begin
        wait (num_steps > 0);
        repeat (num_steps * 64 + 1000) @(posedge clk_col16x_ntsc);
        $display("Error: the run timed out before all steps finished");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial
    begin
        rst_n        = 1'b0;
        ce           = 1'b1;
        rw           = 1'b1;
        adi          = '0;
        dbi          = '0;
        pix_in_valid = 1'b0;
        pix_in_index = '0;
        out_ready    = 1'b1;
        sink_mode    = 0;
        ref_bright   = '0;
        ref_blank    = 1'b0;
        for (int k = 0; k < num_lanes; k++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                ref_pal[k][i] = '0;
            end
        end

        add_step(op_rd_all, 0, 0);           // reset values
        add_step(op_wr, 8'h05, 8'hff);       // red 5, masked to 63
        add_step(op_rd, 8'h05, 8'h3f);
        add_step(op_wr, 8'h1a, 8'h2a);       // green 10
        add_step(op_rd, 8'h1a, 8'h2a);
        add_step(op_wr, 8'h30, 8'hc7);       // bright, 7 kept
        add_step(op_rd, 8'h30, 8'h07);
        add_step(op_wr, 8'h31, 8'hfe);       // blank, bit 0 only
        add_step(op_rd, 8'h31, 8'h00);
        add_step(op_wr, 8'h31, 8'h03);
        add_step(op_rd, 8'h31, 8'h01);
        add_step(op_wr, 8'h37, 8'hff);       // undefined control reg
        add_step(op_rd, 8'h37, 8'h00);
        add_step(op_wr, 8'h31, 8'h00);
        add_step(op_wr, 8'h30, 8'h00);
        add_step(op_pal, 0, 8'h9c);
        add_step(op_rd_all, 0, 0);
        add_step(op_sink, 0, 0);
        add_step(op_burst, 32, 0);           // plain lookup
        add_step(op_drain, 0, 0);
        add_step(op_wr, 8'h30, 20);          // pushes upper entries into saturation
        add_step(op_burst, 32, 3);
        add_step(op_drain, 0, 0);
        add_step(op_wr, 8'h31, 8'h01);       // blanked
        add_step(op_burst, 16, 5);
        add_step(op_drain, 0, 0);
        add_step(op_wr, 8'h31, 8'h00);
        add_step(op_burst, 16, 9);
        add_step(op_drain, 0, 0);
        add_step(op_sink, 1, 0);             // stall the sink
        add_step(op_fill, 0, 0);
        add_step(op_sink, 0, 0);
        add_step(op_drain, 0, 0);
        add_step(op_sink, 2, 0);             // random back-pressure
        add_step(op_burst, 200, 1);
        add_step(op_drain, 0, 0);
        add_step(op_sink, 0, 0);
        add_step(op_rd_all, 0, 0);

        repeat (16) @(posedge clk_col16x_ntsc);
        rst_n <= 1'b1;
        @(posedge clk_col16x_ntsc);
        check_value("out_valid", out_valid, 0);
        check_value("dbo_oe", dbo_oe, 0);
        check_value("pix_in_ready", pix_in_ready, 1);

        for (int s = 0; s < num_steps; s++)
        begin
            case (step_op[s])
                op_wr:     reg_write(6'(step_a[s]), 8'(step_b[s]));
                op_rd:     reg_read(6'(step_a[s]), 8'(step_b[s]));
                op_rd_all: read_all_regs();
                op_pal:    fill_palettes(step_b[s]);
                op_burst:  send_burst(step_a[s], step_b[s]);
                op_sink:   set_sink(step_a[s]);
                op_fill:   fill_until_full();
                default:   drain_outputs();
            endcase
        end

        check_value("scoreboard_left", exp_q.size(), 0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/vid_rgb_top.sv
`timescale 1ns/1ps
`default_nettype none

module vid_rgb_top
    import vid_pkg::*;
(
    input  wire                  clk_col16x_ntsc,
    input  wire                  rst_n,
    // cpu bus
    input  wire                  ce,            // low active
    input  wire                  rw,            // low is write
    input  wire [5:0]            adi,
    input  wire [7:0]            dbi,
    output wire [7:0]            dbo,
    output wire                  dbo_oe,
    // pixel index stream in
    input  wire                  pix_in_valid,
    input  wire [index_w-1:0]    pix_in_index,
    output wire                  pix_in_ready,
    // rgb out
    input  wire                  out_ready,
    output wire                  out_valid,
    output wire [color_w-1:0]    red,
    output wire [color_w-1:0]    green,
    output wire [color_w-1:0]    blue
);

    wire [num_lanes-1:0]              pal_we;      // per lane write strobe
    wire [index_w-1:0]                pal_widx;
    wire [color_w-1:0]                pal_wdata;
    wire [index_w-1:0]                pal_ridx;
    wire [num_lanes-1:0][color_w-1:0] rd_color;    // cpu read data per lane
    wire [color_w-1:0]                bright;
    wire                              blank;
    wire                              push;        // feeder broadcast
    wire [index_w-1:0]                push_index;
    wire [num_lanes-1:0]              credit_ret;
    wire                              pop;         // packer pops every lane
    wire [num_lanes-1:0]              head_valid;
    wire [num_lanes-1:0][color_w-1:0] head_color;

    vid_reg_port reg_port_i (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .ce              (ce),
        .rw              (rw),
        .adi             (adi),
        .dbi             (dbi),
        .rd_color        (rd_color),
        .dbo             (dbo),
        .dbo_oe          (dbo_oe),
        .pal_we          (pal_we),
        .pal_widx        (pal_widx),
        .pal_wdata       (pal_wdata),
        .pal_ridx        (pal_ridx),
        .bright          (bright),
        .blank           (blank)
    );

    pixel_feeder feeder_i (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pix_in_valid    (pix_in_valid),
        .pix_in_index    (pix_in_index),
        .credit_ret      (credit_ret),
        .pix_in_ready    (pix_in_ready),
        .push            (push),
        .push_index      (push_index)
    );

    // lane order follows chan_e, red first
    for (genvar g = 0; g < num_lanes; g++)
    begin : lanes_g
        palette_lane lane_i (
            .clk_col16x_ntsc (clk_col16x_ntsc),
            .rst_n           (rst_n),
            .push            (push),
            .push_index      (push_index),
            .pop             (pop),
            .pal_we          (pal_we[g]),
            .pal_widx        (pal_widx),
            .pal_wdata       (pal_wdata),
            .pal_ridx        (pal_ridx),
            .head_valid      (head_valid[g]),
            .head_color      (head_color[g]),
            .rd_color        (rd_color[g]),
            .credit_ret      (credit_ret[g])
        );
    end

    rgb_packer packer_i (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .head_valid      (head_valid),
        .head_color      (head_color),
        .bright          (bright),
        .blank           (blank),
        .out_ready       (out_ready),
        .pop             (pop),
        .out_valid       (out_valid),
        .red             (red),
        .green           (green),
        .blue            (blue)
    );

endmodule

`default_nettype wire

// File: logic/rgb_packer.sv
`timescale 1ns/1ps
`default_nettype none

module rgb_packer
    import vid_pkg::*;
(
    input  wire                                clk_col16x_ntsc,
    input  wire                                rst_n,
    input  wire [num_lanes-1:0]                head_valid,  // one per lane
    input  wire [num_lanes-1:0][color_w-1:0]   head_color,
    input  wire [color_w-1:0]                  bright,      // added to each channel
    input  wire                                blank,       // force black
    input  wire                                out_ready,
    output logic                               pop,         // to all lanes at once
    output logic                               out_valid,
    output logic [color_w-1:0]                 red,
    output logic [color_w-1:0]                 green,
    output logic [color_w-1:0]                 blue
);

    logic                 load;                  // output reg can take a pixel
    logic [color_w:0]     sum  [num_lanes];      // one extra bit for carry
    logic [color_w-1:0]   chan_d [num_lanes];    // next channel values
    logic [color_w-1:0]   chan_q [num_lanes];    // registered pixel

    assign load = ~out_valid | out_ready;
    assign pop  = (&head_valid) & load;  // all three heads move together

    always_comb
    begin
        for (int i = 0; i < num_lanes; i++)
        begin
            sum[i] = {1'b0, head_color[i]} + {1'b0, bright};
            if (blank)
                chan_d[i] = '0;
            else if (sum[i][color_w])
                chan_d[i] = '1;  // saturate at 63
            else
                chan_d[i] = sum[i][color_w-1:0];
        end
    end

    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= pop;  // empties when nothing is ready
    end

    // pixel payload
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (pop)
        begin
            for (int i = 0; i < num_lanes; i++)
            begin
                chan_q[i] <= chan_d[i];
            end
        end
    end

    assign red   = chan_q[chan_red];
    assign green = chan_q[chan_green];
    assign blue  = chan_q[chan_blue];

    // stalled pixel held intact until the sink takes it
    a_hold_stall: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable({red, green, blue})));

endmodule

`default_nettype wire

// File: logic/palette_lane.sv
`timescale 1ns/1ps
`default_nettype none

module palette_lane
    import vid_pkg::*;
(
    input  wire                  clk_col16x_ntsc,
    input  wire                  rst_n,
    input  wire                  push,        // from feeder
    input  wire [index_w-1:0]    push_index,
    input  wire                  pop,         // shared pop from packer
    input  wire                  pal_we,      // this lane's palette strobe
    input  wire [index_w-1:0]    pal_widx,
    input  wire [color_w-1:0]    pal_wdata,
    input  wire [index_w-1:0]    pal_ridx,    // cpu read index
    output logic                 head_valid,
    output logic [color_w-1:0]   head_color,  // palette value of the head index
    output logic [color_w-1:0]   rd_color,    // palette value for the cpu
    output logic                 credit_ret   // one slot freed last edge
);

    logic [index_w-1:0]              q [lane_depth];        // index queue storage
    logic [$clog2(lane_depth)-1:0]   wr_ptr;
    logic [$clog2(lane_depth)-1:0]   rd_ptr;
    logic [$clog2(lane_depth+1)-1:0] count;                 // 0..lane_depth
    logic [color_w-1:0]              pal_mem [2**index_w];  // 16 x 6 palette

    assign head_valid = (count != '0);

    // lookup at the head, so palette writes hit queued pixels too
    assign head_color = pal_mem[q[rd_ptr]];
    assign rd_color   = pal_mem[pal_ridx];  // combinational, port registers it

    // queue storage, written on push only
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (push)
            q[wr_ptr] <= push_index;
    end

    // pointers and count
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at lane_depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // palette memory, cleared so reads after reset give 0
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 2**index_w; i++)
            begin
                pal_mem[i] <= '0;
            end
        end
        else if (pal_we)
            pal_mem[pal_widx] <= pal_wdata;
    end

    // credit goes back the cycle after the pop
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
            credit_ret <= 1'b0;
        else
            credit_ret <= pop;
    end

    // feeder credits must keep a full lane from being pushed
    a_no_push_full: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        push |-> (count != ($clog2(lane_depth+1))'(lane_depth)));

    // packer only pops when every head is valid
    a_no_pop_empty: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

`default_nettype wire

// File: logic/pixel_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_feeder
    import vid_pkg::*;
(
    input  wire                   clk_col16x_ntsc,
    input  wire                   rst_n,
    input  wire                   pix_in_valid,  // upstream has an index
    input  wire [index_w-1:0]     pix_in_index,
    input  wire [num_lanes-1:0]   credit_ret,    // one credit back per lane
    output logic                  pix_in_ready,  // all lanes have room
    output logic                  push,          // broadcast to every lane
    output logic [index_w-1:0]    push_index
);

    logic [credit_w-1:0]  credit [num_lanes];  // free slots per lane
    logic [num_lanes-1:0] has_credit;

    always_comb
    begin
        for (int i = 0; i < num_lanes; i++)
        begin
            has_credit[i] = (credit[i] != '0);
        end
    end

    // ready straight from the counters, no reset gating
    assign pix_in_ready = &has_credit;
    assign push         = pix_in_valid & pix_in_ready;  // accept and push on the same edge
    assign push_index   = pix_in_index;

    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_lanes; i++)
            begin
                credit[i] <= credit_w'(lane_depth);  // lanes start empty
            end
        end
        else
        begin
            for (int i = 0; i < num_lanes; i++)
            begin
                case ({push, credit_ret[i]})
                    2'b10:   credit[i] <= credit[i] - 1'b1;  // spent
                    2'b01:   credit[i] <= credit[i] + 1'b1;  // returned
                    default: credit[i] <= credit[i];         // both or none cancel
                endcase
            end
        end
    end

    // per lane credit bookkeeping checks
    for (genvar g = 0; g < num_lanes; g++)
    begin : chk_g
        // a lane never hands back more than was pushed into it
        a_no_overflow: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
            (credit_ret[g] && !push) |-> (credit[g] < credit_w'(lane_depth)));

        // an empty counter with no return stays at zero and never wraps
        a_no_underflow: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
            (credit[g] == '0 && !credit_ret[g]) |=> (credit[g] == '0));
    end

endmodule

`default_nettype wire

// File: logic/vid_reg_port.sv
`timescale 1ns/1ps
`default_nettype none

module vid_reg_port
    import vid_pkg::*;
(
    input  wire                                    clk_col16x_ntsc,
    input  wire                                    rst_n,
    input  wire                                    ce,         // chip enable, low active
    input  wire                                    rw,         // low means write
    input  wire [5:0]                              adi,        // register address
    input  wire [7:0]                              dbi,        // cpu write data
    input  wire [num_lanes-1:0][color_w-1:0]       rd_color,   // palette entry from each lane
    output logic [7:0]                             dbo,        // read data, one cycle late
    output logic                                   dbo_oe,     // drive data bus
    output logic [num_lanes-1:0]                   pal_we,     // one strobe per lane
    output logic [index_w-1:0]                     pal_widx,
    output logic [color_w-1:0]                     pal_wdata,
    output logic [index_w-1:0]                     pal_ridx,
    output logic [color_w-1:0]                     bright,
    output logic                                   blank
);

    reg_addr_u  addr_u;   // decoded address
    logic       wr_cyc;   // cpu write this edge
    logic       rd_cyc;   // cpu read this edge
    logic       is_ctrl;  // control view selected
    logic [7:0] rd_data;  // read mux

    assign addr_u  = adi;
    assign wr_cyc  = ~ce & ~rw;
    assign rd_cyc  = ~ce & rw;
    assign is_ctrl = (addr_u.ctrl.kind == chan_ctrl);

    // palette write side is shared, only the strobe differs per lane
    assign pal_widx  = addr_u.pal.pal_idx;
    assign pal_wdata = dbi[color_w-1:0];  // upper data bits dropped
    assign pal_ridx  = addr_u.pal.pal_idx;

    always_comb
    begin
        for (int i = 0; i < num_lanes; i++)
        begin
            pal_we[i] = wr_cyc && !is_ctrl && (addr_u.pal.kind == chan_e'(i));
        end
    end

    // control registers
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bright <= '0;
            blank  <= 1'b0;
        end
        else if (wr_cyc && is_ctrl)
        begin
            if (addr_u.ctrl.reg_num == ctrl_bright)
                bright <= dbi[color_w-1:0];
            if (addr_u.ctrl.reg_num == ctrl_blank)
                blank <= dbi[0];  // only bit 0 kept
        end
    end

    // read data select
    always_comb
    begin
        rd_data = 8'h00;  // undefined control regs read 0
        if (is_ctrl)
        begin
            case (addr_u.ctrl.reg_num)
                ctrl_bright: rd_data = 8'(bright);
                ctrl_blank:  rd_data = 8'(blank);
                default:     rd_data = 8'h00;
            endcase
        end
        else
            rd_data = 8'(rd_color[addr_u.pal.kind]);  // lane named by kind
    end

    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
            dbo_oe <= 1'b0;
        else
            dbo_oe <= rd_cyc;  // held only for the cycle after a read
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rd_cyc)
            dbo <= rd_data;
    end

    // a single cpu access never targets two palettes
    a_one_pal_we: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        $onehot0(pal_we));

endmodule

`default_nettype wire

// File: logic/vid_pkg.sv
`default_nettype none

package vid_pkg;

    // pixel path geometry
    localparam int num_lanes  = 3;  // red, green, blue
    localparam int lane_depth = 4;  // index queue entries per lane, also initial credit
    localparam int color_w    = 6;  // bits per channel value
    localparam int index_w    = 4;  // colour index width, 16 palette entries
    localparam int credit_w   = 3;  // holds 0..lane_depth

    // kind field of a cpu register address
    typedef enum logic [1:0] {
        chan_red   = 2'd0,
        chan_green = 2'd1,
        chan_blue  = 2'd2,
        chan_ctrl  = 2'd3
    } chan_e;

    // palette view of the address
    typedef struct packed {
        chan_e      kind;     // which palette
        logic [3:0] pal_idx;  // entry within it
    } pal_addr_t;

    // control view, only when kind is chan_ctrl
    typedef struct packed {
        chan_e      kind;
        logic [3:0] reg_num;  // control register number
    } ctrl_addr_t;

    // 6 bit cpu address seen either way
    typedef union packed {
        pal_addr_t  pal;
        ctrl_addr_t ctrl;
    } reg_addr_u;

    // control register numbers
    localparam logic [3:0] ctrl_bright = 4'd0;  // 6 bit brightness offset
    localparam logic [3:0] ctrl_blank  = 4'd1;  // bit 0 forces black

endpackage

`default_nettype wire
